/* mac_glue.f */
+incdir+test
hdl/mac_bus_pkg.sv
hdl/mac_periph_pkg.sv
hdl/mac_bus_if.sv
hdl/mac_bus_decode.sv
hdl/mac_via.sv
hdl/mac_scc_mouse.sv
hdl/mac_glue_top.sv
test/mac_glue_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mac_glue_tb
FILELIST  := mac_glue.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/mac_glue_tests.svh */
`ifndef MAC_GLUE_TESTS_SVH
`define MAC_GLUE_TESTS_SVH

// ==============================
// Directed tests
// ==============================

task automatic reset_and_overlay();
  int                 errs;
  logic [31:0]        r;
  mac_bus_pkg::byte_t d;
  mac_bus_pkg::word_t rd;
  errs = error_count;
  r    = lcg_next();
  d    = r[7:0];
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  check_bit("o_overlay", overlay, 1'b0);   // Port A resets to 7F
  via_write(mac_periph_pkg::via_port_a, d);
  check_bit("o_overlay", overlay, ~d[4]);
  wb_read(via_addr(mac_periph_pkg::via_port_a), rd);
  check_byte("o_wb_dat[15:8] port A", rd[15:8], {1'b1, d[6:0]});
  check_byte("o_wb_dat[7:0]", rd[7:0], 8'hEF); // Filler lane
  report_test("reset_and_overlay", errs);
endtask

task automatic irq_enable_rules();
  int                 errs;
  logic [31:0]        r;
  logic [6:0]         en;
  mac_bus_pkg::word_t rd;
  errs = error_count;
  r    = lcg_next();
  en   = r[6:0];
  via_write(mac_periph_pkg::via_ier, {1'b1, en});          // Set mode
  wb_read(via_addr(mac_periph_pkg::via_ier), rd);
  check_byte("o_wb_dat[15:8] IER", rd[15:8], {1'b0, en});
  via_write(mac_periph_pkg::via_ier, 8'h82);               // Adds vblank to the set
  wb_read(via_addr(mac_periph_pkg::via_ier), rd);
  check_byte("o_wb_dat[15:8] IER", rd[15:8], {1'b0, en | 7'h02});
  via_write(mac_periph_pkg::via_ier, {1'b0, en & 7'h7D});  // Clear all but vblank
  wb_read(via_addr(mac_periph_pkg::via_ier), rd);
  check_byte("o_wb_dat[15:8] IER", rd[15:8], 8'h02);
  pulse_vsync();
  check_ipl("o_ipl_n", ipl_n, 3'b110);
  wb_read(via_addr(mac_periph_pkg::via_ifr), rd);
  check_byte("o_wb_dat[15:8] IFR", rd[15:8], 8'h82);
  via_write(mac_periph_pkg::via_ifr, 8'h02);              // Ones clear
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  report_test("irq_enable_rules", errs);
endtask

task automatic timer2_one_shot();
  int                 errs, n, cycles;
  logic [31:0]        r;
  mac_bus_pkg::word_t rd;
  errs = error_count;
  r    = lcg_next();
  n    = 1 + int'(r % 32'd6);
  via_write(mac_periph_pkg::via_ier, 8'hA0);
  via_write(mac_periph_pkg::via_t2c_lo, 8'(n));
  via_write(mac_periph_pkg::via_t2c_hi, 8'h00);  // Loads and arms
  cycles = 1;                                    // One edge since the load
  while (ipl_n != 3'b110 && cycles < (n + 2) * 20) begin
    @(posedge clk_cpu);
    #2;
    cycles++;
  end
  if (ipl_n != 3'b110) begin
    $display("Timer 2 flag missing %0d cycles after loading %0d", cycles, n);
    error_count++;
  end else if (cycles < n * 20) begin
    $display("Timer 2 flag came after %0d cycles, before %0d", cycles, n * 20);
    error_count++;
  end
  wb_read(via_addr(mac_periph_pkg::via_t2c_lo), rd); // Read clears the flag
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  via_write(mac_periph_pkg::via_ier, 8'h20);
  report_test("timer2_one_shot", errs);
endtask

task automatic one_second_irq();
  int                 errs;
  mac_bus_pkg::word_t rd;
  errs = error_count;
  apply_reset();                                 // Frame count back to 0
  via_write(mac_periph_pkg::via_ier, 8'h83);
  repeat (59) pulse_vsync();
  wb_read(via_addr(mac_periph_pkg::via_ifr), rd);
  check_byte("o_wb_dat[15:8] IFR", rd[15:8], 8'h82);
  pulse_vsync();                                 // 60th frame
  wb_read(via_addr(mac_periph_pkg::via_ifr), rd);
  check_byte("o_wb_dat[15:8] IFR", rd[15:8], 8'h83);
  check_ipl("o_ipl_n", ipl_n, 3'b110);
  wb_read(via_addr(mac_periph_pkg::via_port_a), rd);
  wb_read(via_addr(mac_periph_pkg::via_ifr), rd);
  check_byte("o_wb_dat[15:8] IFR", rd[15:8], 8'h00);
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  via_write(mac_periph_pkg::via_ier, 8'h03);
  report_test("one_second_irq", errs);
endtask

task automatic scc_mouse_irq();
  int                 errs;
  mac_bus_pkg::word_t rd;
  errs = error_count;
  scc_write(1'b1, 8'h0F);                        // Pointer to WR15
  scc_write(1'b1, 8'h08);                        // DCD interrupt enable
  scc_write(1'b1, 8'h01);                        // Pointer to WR1
  scc_write(1'b1, 8'h01);                        // Ext/status enable
  scc_write(1'b1, 8'h09);                        // Pointer to WR9
  scc_write(1'b1, 8'h08);                        // Master enable
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  mouse_x1 = 1'b1;
  @(posedge clk_cpu);
  #2;
  check_ipl("o_ipl_n", ipl_n, 3'b101);
  scc_write(1'b1, 8'h03);                        // Pointer to RR3
  wb_read(scc_addr(1'b1), rd);
  check_byte("o_wb_dat[15:8] RR3A", rd[15:8], 8'h08);
  wb_read(scc_addr(1'b1), rd);                   // Pointer back at RR0
  check_byte("o_wb_dat[15:8] RR0A", rd[15:8], {4'b0100, mouse_x1, 3'b100});
  scc_write(1'b1, 8'h10);                        // Reset ext/status
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  report_test("scc_mouse_irq", errs);
endtask

task automatic irq_priority();
  int errs;
  errs     = error_count;
  mouse_x1 = 1'b0;                               // Latch reopened, moves again
  @(posedge clk_cpu);
  #2;
  check_ipl("o_ipl_n", ipl_n, 3'b101);
  via_write(mac_periph_pkg::via_ier, 8'h82);
  pulse_vsync();
  check_ipl("o_ipl_n", ipl_n, 3'b110);           // VIA above SCC
  via_write(mac_periph_pkg::via_ifr, 8'h02);
  check_ipl("o_ipl_n", ipl_n, 3'b101);
  scc_write(1'b1, 8'h10);
  via_write(mac_periph_pkg::via_ier, 8'h02);
  check_ipl("o_ipl_n", ipl_n, 3'b111);
  report_test("irq_priority", errs);
endtask

`endif

/* test/mac_glue_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mac_glue_tb;

  localparam int clk_period  = 40;
  localparam int vsync_edges = 62;  // Falling edges driven over all tests
  localparam int watchdog_ns = 200_000 + 80 * clk_period * vsync_edges;

  logic                clk_cpu;
  logic                reset;
  logic                wb_cyc, wb_stb, wb_we, wb_ack;
  mac_bus_pkg::waddr_t wb_adr;
  logic [1:0]          wb_sel;
  mac_bus_pkg::word_t  wb_dat_w, wb_dat_r;
  mac_bus_pkg::ipl_t   ipl_n;
  logic                overlay;
  logic                vsync, hsync, mouse_x1, mouse_y1, mouse_x2, mouse_y2, mouse_button;

  int          error_count  = 0;
  int          test_count   = 0;
  int          failed_tests = 0;
  logic [31:0] rng_state    = 32'hea4276d2;

  mac_glue_top mac_glue_top_inst (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_wb_cyc       (wb_cyc),
    .i_wb_stb       (wb_stb),
    .i_wb_we        (wb_we),
    .i_wb_adr       (wb_adr),
    .i_wb_sel       (wb_sel),
    .i_wb_dat       (wb_dat_w),
    .o_wb_dat       (wb_dat_r),
    .o_wb_ack       (wb_ack),
    .o_ipl_n        (ipl_n),
    .o_overlay      (overlay),
    .i_vsync        (vsync),
    .i_hsync        (hsync),
    .i_mouse_x1     (mouse_x1),
    .i_mouse_y1     (mouse_y1),
    .i_mouse_x2     (mouse_x2),
    .i_mouse_y2     (mouse_y2),
    .i_mouse_button (mouse_button)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #(clk_period / 2) clk_cpu = ~clk_cpu;
  end

  // Ends a hung run
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the run never reached its end", watchdog_ns);
    $display("Some tests failed");
    $finish;
  end

  // ==============================
  // Stimulus helpers
  // ==============================
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG
    return rng_state;
  endfunction

  function automatic mac_bus_pkg::waddr_t via_addr(input mac_periph_pkg::via_reg_t r);
    logic [23:0] a;
    a       = {mac_bus_pkg::page_via, 20'hFE1FE}; // Usual VIA base
    a[12:9] = r;
    return a[23:1];
  endfunction

  // SCC control port, channel A or B
  function automatic mac_bus_pkg::waddr_t scc_addr(input logic chan_a);
    logic [23:0] a;
    a    = {mac_bus_pkg::page_scc_match, 20'h0};
    a[1] = chan_a;
    return a[23:1];
  endfunction

  // Entered and left 2 ns after a rising edge
  task automatic bus_access(input mac_bus_pkg::waddr_t adr, input logic we,
                            input mac_bus_pkg::word_t wdat, output mac_bus_pkg::word_t rdat);
    int waited;
    waited   = 0;
    wb_adr   = adr;
    wb_we    = we;
    wb_dat_w = wdat;
    wb_sel   = 2'b10;            // Upper lane
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    @(posedge clk_cpu);
    #2;
    while (!wb_ack && waited < 8) begin
      @(posedge clk_cpu);
      #2;
      waited++;
    end
    if (!wb_ack) begin
      $display("No acknowledge for the access at word address %h", adr);
      error_count++;
    end
    rdat = wb_dat_r;             // Valid during ack
    @(posedge clk_cpu);          // Ack seen, write commits here
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk_cpu);          // Idle cycle moves the SCC pointer
    #2;
  endtask

  task automatic wb_write(input mac_bus_pkg::waddr_t adr, input mac_bus_pkg::word_t dat);
    mac_bus_pkg::word_t ignored;
    bus_access(adr, 1'b1, dat, ignored);
  endtask

  task automatic wb_read(input mac_bus_pkg::waddr_t adr, output mac_bus_pkg::word_t dat);
    bus_access(adr, 1'b0, 16'h0000, dat);
  endtask

  task automatic via_write(input mac_periph_pkg::via_reg_t r, input mac_bus_pkg::byte_t b);
    wb_write(via_addr(r), {b, 8'h00});
  endtask

  task automatic scc_write(input logic chan_a, input mac_bus_pkg::byte_t b);
    wb_write(scc_addr(chan_a), {b, 8'h00});
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(posedge clk_cpu);
    #2;
    reset = 1'b0;
  endtask

  task automatic pulse_vsync();
    vsync = 1'b1;
    @(posedge clk_cpu);
    #2;
    vsync = 1'b0;                // Falling edge, flag set at next clock
    @(posedge clk_cpu);
    #2;
  endtask

  // ==============================
  // Compare and report
  // ==============================
  task automatic check_byte(input string name, input mac_bus_pkg::byte_t got,
                            input mac_bus_pkg::byte_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_ipl(input string name, input mac_bus_pkg::ipl_t got,
                           input mac_bus_pkg::ipl_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d checks wrong", name, error_count - errors_before);
      failed_tests++;
    end
  endtask

  `include "mac_glue_tests.svh"

  initial begin
    reset        = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_sel       = 2'b00;
    wb_dat_w     = '0;
    vsync        = 1'b0;
    hsync        = 1'b0;
    mouse_x1     = 1'b0;
    mouse_y1     = 1'b0;
    mouse_x2     = 1'b0;
    mouse_y2     = 1'b0;
    mouse_button = 1'b0;
    apply_reset();
    reset_and_overlay();
    irq_enable_rules();
    timer2_one_shot();
    one_second_irq();
    scc_mouse_irq();
    irq_priority();
    $display("Summary: %0d tests, %0d failed, %0d wrong checks",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/mac_glue_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mac_glue_top (
  input  wire                 clk_cpu,
  input  wire                 reset,
  input  wire                 i_wb_cyc,
  input  wire                 i_wb_stb,
  input  wire                 i_wb_we,
  input  mac_bus_pkg::waddr_t i_wb_adr,
  input  wire [1:0]           i_wb_sel,     // Bit 1 is the upper byte
  input  mac_bus_pkg::word_t  i_wb_dat,
  output mac_bus_pkg::word_t  o_wb_dat,
  output logic                o_wb_ack,
  output mac_bus_pkg::ipl_t   o_ipl_n,
  output logic                o_overlay,
  input  wire                 i_vsync,
  input  wire                 i_hsync,
  input  wire                 i_mouse_x1,
  input  wire                 i_mouse_y1,
  input  wire                 i_mouse_x2,
  input  wire                 i_mouse_y2,
  input  wire                 i_mouse_button
);

  logic via_irq;
  logic scc_irq;

  mac_bus_if bus ();

  // ==============================
  // Decode and peripherals
  // ==============================
  mac_bus_decode mac_bus_decode_inst (
    .clk_cpu   (clk_cpu),
    .reset     (reset),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_sel  (i_wb_sel),
    .i_wb_dat  (i_wb_dat),
    .o_wb_dat  (o_wb_dat),
    .o_wb_ack  (o_wb_ack),
    .i_via_irq (via_irq),
    .i_scc_irq (scc_irq),
    .o_ipl_n   (o_ipl_n),
    .bus       (bus)
  );

  mac_via mac_via_inst (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .bus            (bus),
    .i_vsync        (i_vsync),
    .i_hsync        (i_hsync),
    .i_mouse_x2     (i_mouse_x2),     // Quadrature second phases
    .i_mouse_y2     (i_mouse_y2),
    .i_mouse_button (i_mouse_button),
    .o_overlay      (o_overlay),
    .o_irq          (via_irq)
  );

  mac_scc_mouse mac_scc_mouse_inst (
    .clk_cpu    (clk_cpu),
    .reset      (reset),
    .bus        (bus),
    .i_mouse_x1 (i_mouse_x1),         // DCD A
    .i_mouse_y1 (i_mouse_y1),         // DCD B
    .o_irq      (scc_irq)
  );

endmodule

`default_nettype wire

/* hdl/mac_scc_mouse.sv */
`timescale 1ns/100ps
`default_nettype none

module mac_scc_mouse (
  input  wire    clk_cpu,
  input  wire    reset,
  mac_bus_if.scc bus,
  input  wire    i_mouse_x1,
  input  wire    i_mouse_y1,
  output logic   o_irq
);

  // Channel index 1 is A (mouse x1), 0 is B (mouse y1)
  logic [1:0]               rs;        // Bit 1 data/control, bit 0 channel A
  mac_bus_pkg::byte_t       wdat;
  logic                     acc, ctl_acc, wr9_cmd, full_reset;
  logic [1:0]               wr_ch, chan_reset, ext_reset, do_latch, mouse;
  mac_periph_pkg::scc_reg_t rindex, rindex_latch;

  mac_bus_pkg::byte_t wr1 [2];
  mac_bus_pkg::byte_t wr15 [2];
  logic [5:0]         wr9;       // Command bits 7:6 are not kept
  logic [1:0]         dcd_latch, latch_open, ext_ip;
  mac_bus_pkg::byte_t rr0 [2];
  mac_bus_pkg::byte_t rr2_b, rr3_a;
  logic [2:0]         vec_stat;

  assign rs      = bus.adr[2:1];
  assign wdat    = bus.wdat_hi;
  assign mouse   = {i_mouse_x1, i_mouse_y1};
  assign acc     = bus.scc_sel & bus.commit;
  assign ctl_acc = acc & ~rs[1];
  assign wr_ch   = {ctl_acc & bus.we & rs[0], ctl_acc & bus.we & ~rs[0]};

  // WR9 software resets
  assign wr9_cmd    = |wr_ch && (rindex == mac_periph_pkg::scc_wr9);
  assign full_reset = reset | (wr9_cmd && wdat[7:6] == 2'b11);
  assign chan_reset = {full_reset | (wr9_cmd && wdat[7:6] == 2'b10),
                       full_reset | (wr9_cmd && wdat[7:6] == 2'b01)};

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      ext_reset[c] = wr_ch[c] && (rindex == mac_periph_pkg::scc_rr0) &&
                     (wdat[5:3] == mac_periph_pkg::cmd_reset_ext);
      do_latch[c]  = latch_open[c] && (mouse[c] != dcd_latch[c]) &&
                     wr15[c][mac_periph_pkg::dcd_ie_bit];
    end
  end

  // ==============================
  // Write registers
  // ==============================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      wr9    <= '0;
      wr1[0] <= '0;
      wr1[1] <= '0;
    end else begin
      if (wr9_cmd) wr9 <= wdat[5:0]; // Shared by both channels
      for (int c = 0; c < 2; c++) begin
        if (chan_reset[c]) begin
          wr1[c] <= wr1[c] & 8'h24; // Bits 5 and 2 survive a channel reset
        end else if (wr_ch[c] && rindex == mac_periph_pkg::scc_wr1) begin
          wr1[c] <= wdat;
        end
      end
    end
  end

  // Pointer moves only once the access is over
  always_ff @(posedge clk_cpu) begin
    if (reset) rindex <= '0;
    else if (!bus.scc_sel) rindex <= rindex_latch;
  end

  // ==============================
  // Pointer, DCD latches, pending
  // ==============================
  always_ff @(posedge clk_cpu) begin
    if (full_reset) begin
      rindex_latch <= '0;
      dcd_latch    <= '0;
      latch_open   <= '1;
      ext_ip       <= '0;
      wr15[0]      <= mac_periph_pkg::wr15_reset;
      wr15[1]      <= mac_periph_pkg::wr15_reset;
    end else begin
      if (ctl_acc) begin
        rindex_latch <= '0;               // Any control access falls back to WR0
        if (bus.we && rindex == mac_periph_pkg::scc_rr0) begin
          rindex_latch <= {wdat[5:3] == 3'b001, wdat[2:0]}; // Point high adds 8
        end
      end
      for (int c = 0; c < 2; c++) begin
        if (wr_ch[c] && rindex == mac_periph_pkg::scc_wr15) wr15[c] <= wdat;
        if (ext_reset[c]) begin
          latch_open[c] <= 1'b1;
          ext_ip[c]     <= 1'b0;
        end else if (do_latch[c]) begin
          latch_open[c] <= 1'b0;
          if (wr1[c][mac_periph_pkg::ext_ie_bit]) ext_ip[c] <= 1'b1;
        end
        if (do_latch[c]) dcd_latch[c] <= mouse[c];
      end
    end
  end

  assign o_irq = wr9[mac_periph_pkg::mie_bit] & |ext_ip;

  // ==============================
  // Read registers
  // ==============================
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      rr0[c] = {4'b0100, wr15[c][mac_periph_pkg::dcd_ie_bit] ? dcd_latch[c] : mouse[c], 3'b100};
    end
  end

  assign vec_stat = ext_ip[1] ? 3'b101 : ext_ip[0] ? 3'b001 : 3'b011;
  assign rr2_b    = {4'b0000, vec_stat, 1'b0};
  assign rr3_a    = {4'b0000, ext_ip[1], 2'b00, ext_ip[0]};

  always_comb begin
    case (rindex)
      mac_periph_pkg::scc_rr0: bus.scc_rdat = rr0[rs[0]];
      mac_periph_pkg::scc_rr2: bus.scc_rdat = rs[0] ? 8'h00 : rr2_b; // B side only
      mac_periph_pkg::scc_rr3: bus.scc_rdat = rs[0] ? rr3_a : 8'h00; // A side only
      default:                 bus.scc_rdat = 8'h00;
    endcase
  end

  a_ip_closed: assert property (@(posedge clk_cpu) disable iff (reset)
    (ext_ip & latch_open) == 2'b00);

endmodule

`default_nettype wire

/* hdl/mac_via.sv */
`timescale 1ns/100ps
`default_nettype none

module mac_via (
  input  wire    clk_cpu,
  input  wire    reset,
  mac_bus_if.via bus,
  input  wire    i_vsync,
  input  wire    i_hsync,
  input  wire    i_mouse_x2,
  input  wire    i_mouse_y2,
  input  wire    i_mouse_button,
  output logic   o_overlay,
  output logic   o_irq
);

  mac_periph_pkg::via_reg_t reg_idx;
  mac_bus_pkg::byte_t       wdat;
  logic                     acc, wr_acc, rd_acc;

  mac_bus_pkg::byte_t port_a, port_b;
  logic               ddr_b0;                 // Only bit 0 of DDR B is kept
  mac_bus_pkg::byte_t acr;
  logic [15:0]        t1_count, t1_latch;     // Storage, timer 1 does not run
  logic [15:0]        t2_count;
  mac_bus_pkg::byte_t t2_latch_lo;
  logic               t2_armed;
  logic [mac_periph_pkg::via_flags_w-1:0] ifr, ier;

  logic [4:0] div_cnt;
  logic       tick, load_t2;
  logic       vsync_q, vsync_fall;
  logic [5:0] vsync_cnt;

  assign reg_idx = bus.adr[12:9];
  assign wdat    = bus.wdat_hi;
  assign acc     = bus.via_sel & bus.commit;
  assign wr_acc  = acc & bus.we;
  assign rd_acc  = acc & ~bus.we;
  assign load_t2 = wr_acc && (reg_idx == mac_periph_pkg::via_t2c_hi);

  assign vsync_fall = vsync_q & ~i_vsync;
  assign tick       = (div_cnt == '0);

  // ==============================
  // Timer tick, clk_cpu / 20
  // ==============================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (div_cnt == 5'(mac_periph_pkg::timer_div - 1)) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 5'd1;
    end
  end

  // Timer 1 holds whatever software writes
  always_ff @(posedge clk_cpu) begin
    if (wr_acc) begin
      case (reg_idx)
        mac_periph_pkg::via_t1c_lo: t1_count[7:0]  <= wdat;
        mac_periph_pkg::via_t1c_hi: t1_count[15:8] <= wdat;
        mac_periph_pkg::via_t1l_lo: t1_latch[7:0]  <= wdat;
        mac_periph_pkg::via_t1l_hi: t1_latch[15:8] <= wdat;
        mac_periph_pkg::via_t2c_lo: t2_latch_lo    <= wdat; // Held until T2 high
        default: ;
      endcase
    end
  end

  // ==============================
  // Registers and flags
  // ==============================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      port_a    <= mac_periph_pkg::via_port_a_reset;
      port_b    <= mac_periph_pkg::via_port_b_reset;
      ddr_b0    <= 1'b1;
      acr       <= '0;
      ifr       <= '0;
      ier       <= '0;
      t2_count  <= '0;
      t2_armed  <= 1'b0;
      vsync_q   <= 1'b0;
      vsync_cnt <= '0;
    end else begin
      vsync_q <= i_vsync;
      if (wr_acc) begin
        case (reg_idx)
          mac_periph_pkg::via_port_b: port_b <= wdat;
          mac_periph_pkg::via_ddr_b:  ddr_b0 <= wdat[0];
          mac_periph_pkg::via_t2c_hi: begin
            t2_count <= {wdat, t2_latch_lo};
            t2_armed <= 1'b1;
            ifr[mac_periph_pkg::int_t2] <= 1'b0;
          end
          mac_periph_pkg::via_acr: acr <= wdat;
          mac_periph_pkg::via_ifr: ifr <= ifr & ~wdat[6:0]; // Ones clear
          mac_periph_pkg::via_ier: begin
            if (wdat[7]) ier <= ier | wdat[6:0];             // Set mode
            else         ier <= ier & ~wdat[6:0];            // Clear mode
          end
          mac_periph_pkg::via_port_a: port_a <= wdat;
          default: ;
        endcase
      end else if (rd_acc) begin
        case (reg_idx)
          mac_periph_pkg::via_t2c_lo: ifr[mac_periph_pkg::int_t2] <= 1'b0;
          mac_periph_pkg::via_port_a: begin
            ifr[mac_periph_pkg::int_onesec] <= 1'b0;
            ifr[mac_periph_pkg::int_vblank] <= 1'b0;
          end
          default: ;
        endcase
      end

      // Events below win over a clear in the same cycle
      if (vsync_fall) begin
        ifr[mac_periph_pkg::int_vblank] <= 1'b1;
        if (vsync_cnt == 6'(mac_periph_pkg::frames_per_sec - 1)) begin
          ifr[mac_periph_pkg::int_onesec] <= 1'b1;
          vsync_cnt <= '0;
        end else begin
          vsync_cnt <= vsync_cnt + 6'd1;
        end
      end

      // One-shot, counter keeps running after it fires
      if (tick && !load_t2) begin
        if (t2_armed && t2_count == '0) begin
          ifr[mac_periph_pkg::int_t2] <= 1'b1;
          t2_armed <= 1'b0;
        end
        t2_count <= t2_count - 16'd1;
      end
    end
  end

  assign o_irq     = |(ifr & ier);
  assign o_overlay = ~port_a[mac_periph_pkg::overlay_bit];

  // ==============================
  // Read mux
  // ==============================
  always_comb begin
    case (reg_idx)
      mac_periph_pkg::via_port_b: bus.via_rdat = {port_b[7], ~i_hsync, i_mouse_y2, i_mouse_x2,
                                                  i_mouse_button, port_b[2:1], port_b[0]};
      mac_periph_pkg::via_ddr_b:  bus.via_rdat = {7'b1000011, ddr_b0};
      mac_periph_pkg::via_t1c_lo: bus.via_rdat = t1_count[7:0];
      mac_periph_pkg::via_t1c_hi: bus.via_rdat = t1_count[15:8];
      mac_periph_pkg::via_t1l_lo: bus.via_rdat = t1_latch[7:0];
      mac_periph_pkg::via_t1l_hi: bus.via_rdat = t1_latch[15:8];
      mac_periph_pkg::via_t2c_lo: bus.via_rdat = t2_count[7:0];
      mac_periph_pkg::via_t2c_hi: bus.via_rdat = t2_count[15:8];
      mac_periph_pkg::via_sr,
      mac_periph_pkg::via_pcr:    bus.via_rdat = 8'h00;  // No shift register or handshake
      mac_periph_pkg::via_acr:    bus.via_rdat = acr;
      mac_periph_pkg::via_ifr:    bus.via_rdat = {o_irq, ifr}; // Bit 7 is any enabled flag
      mac_periph_pkg::via_ier:    bus.via_rdat = {1'b0, ier};
      mac_periph_pkg::via_port_a: bus.via_rdat = {1'b1, port_a[6:0]}; // SCC wait/req high
      default:                    bus.via_rdat = 8'hBE;
    endcase
  end

  a_t2_armed: assert property (@(posedge clk_cpu) disable iff (reset)
    $rose(ifr[mac_periph_pkg::int_t2]) |-> $past(t2_armed));

endmodule

`default_nettype wire

/* hdl/mac_bus_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module mac_bus_decode (
  input  wire                 clk_cpu,
  input  wire                 reset,
  input  wire                 i_wb_cyc,
  input  wire                 i_wb_stb,
  input  wire                 i_wb_we,
  input  mac_bus_pkg::waddr_t i_wb_adr,
  input  wire [1:0]           i_wb_sel,
  input  mac_bus_pkg::word_t  i_wb_dat,
  output mac_bus_pkg::word_t  o_wb_dat,
  output logic                o_wb_ack,
  input  wire                 i_via_irq,
  input  wire                 i_scc_irq,
  output mac_bus_pkg::ipl_t   o_ipl_n,
  mac_bus_if.decode           bus
);

  logic req;   // Live request from the master
  logic ack_q;

  assign req = i_wb_cyc & i_wb_stb;

  // ==============================
  // Address decode
  // ==============================
  assign bus.via_sel = req && (i_wb_adr[23:20] == mac_bus_pkg::page_via) && i_wb_sel[1];
  assign bus.scc_sel = req && |i_wb_sel &&
                       ((i_wb_adr[23:20] & mac_bus_pkg::page_scc_mask)
                        == mac_bus_pkg::page_scc_match);
  assign bus.we      = i_wb_we;
  assign bus.adr     = i_wb_adr;
  assign bus.wdat_hi = i_wb_dat[15:8];
  assign bus.commit  = ack_q;

  // One wait state, then ack for a single cycle
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q; // Drops after one cycle even if stb stays high
    end
  end

  assign o_wb_ack = ack_q;

  // Read data sampled in the wait cycle, held through ack
  always_ff @(posedge clk_cpu) begin
    if (bus.via_sel) begin
      o_wb_dat <= {bus.via_rdat, mac_bus_pkg::fill_byte};
    end else if (bus.scc_sel) begin
      o_wb_dat <= {bus.scc_rdat, mac_bus_pkg::fill_byte};
    end else begin
      o_wb_dat <= '0; // Unmapped space
    end
  end

  // ==============================
  // Interrupt priority
  // ==============================
  assign o_ipl_n = i_via_irq ? mac_periph_pkg::ipl_via  :  // VIA wins
                   i_scc_irq ? mac_periph_pkg::ipl_scc  :
                               mac_periph_pkg::ipl_none;

  a_ack_single: assert property (@(posedge clk_cpu) disable iff (reset)
    o_wb_ack |=> !o_wb_ack);

  a_sel_exclusive: assert property (@(posedge clk_cpu) disable iff (reset)
    !(bus.via_sel && bus.scc_sel));

endmodule

`default_nettype wire

/* hdl/mac_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Decoded peripheral access, one per bus cycle
interface mac_bus_if;

  logic                  via_sel;  // VIA window, upper lane
  logic                  scc_sel;  // SCC window, any lane
  logic                  commit;   // Ack cycle, state changes at its end
  logic                  we;
  mac_bus_pkg::waddr_t   adr;
  mac_bus_pkg::byte_t    wdat_hi;  // Upper data byte
  mac_bus_pkg::byte_t    via_rdat;
  mac_bus_pkg::byte_t    scc_rdat;

  modport decode (output via_sel, scc_sel, commit, we, adr, wdat_hi,
                  input  via_rdat, scc_rdat);

  modport via (input  via_sel, commit, we, adr, wdat_hi,
               output via_rdat);

  modport scc (input  scc_sel, commit, we, adr, wdat_hi,
               output scc_rdat);

endinterface

`default_nettype wire

/* hdl/mac_periph_pkg.sv */
`default_nettype none

package mac_periph_pkg;

  // ==============================
  // VIA
  // ==============================
  typedef logic [3:0] via_reg_t; // Register select, address bits 12:9

  localparam via_reg_t via_port_b = 4'h0;
  localparam via_reg_t via_ddr_b  = 4'h2;
  localparam via_reg_t via_t1c_lo = 4'h4;
  localparam via_reg_t via_t1c_hi = 4'h5;
  localparam via_reg_t via_t1l_lo = 4'h6;
  localparam via_reg_t via_t1l_hi = 4'h7;
  localparam via_reg_t via_t2c_lo = 4'h8;
  localparam via_reg_t via_t2c_hi = 4'h9; // Write loads and arms timer 2
  localparam via_reg_t via_sr     = 4'hA;
  localparam via_reg_t via_acr    = 4'hB;
  localparam via_reg_t via_pcr    = 4'hC;
  localparam via_reg_t via_ifr    = 4'hD;
  localparam via_reg_t via_ier    = 4'hE;
  localparam via_reg_t via_port_a = 4'hF;

  // Interrupt flag positions
  localparam int int_onesec  = 0;
  localparam int int_vblank  = 1;
  localparam int int_t2      = 5;
  localparam int via_flags_w = 7;

  localparam int timer_div      = 20; // clk_cpu cycles per timer tick
  localparam int frames_per_sec = 60;

  localparam logic [7:0] via_port_a_reset = 8'h7F;
  localparam logic [7:0] via_port_b_reset = 8'hFF;
  localparam int         overlay_bit      = 4;     // Port A, low maps ROM at 0

  // ==============================
  // SCC
  // ==============================
  typedef logic [3:0] scc_reg_t;

  localparam scc_reg_t scc_wr1  = 4'd1;
  localparam scc_reg_t scc_wr9  = 4'd9;
  localparam scc_reg_t scc_wr15 = 4'd15;
  localparam scc_reg_t scc_rr0  = 4'd0;  // Also WR0, the command register
  localparam scc_reg_t scc_rr2  = 4'd2;
  localparam scc_reg_t scc_rr3  = 4'd3;

  localparam logic [7:0] wr15_reset    = 8'hF8;
  localparam int         dcd_ie_bit    = 3;      // WR15
  localparam int         ext_ie_bit    = 0;      // WR1
  localparam int         mie_bit       = 3;      // WR9
  localparam logic [2:0] cmd_reset_ext = 3'b010; // WR0 bits 5:3

  // Priority codes on the IPL lines
  localparam mac_bus_pkg::ipl_t ipl_via  = 3'b110;
  localparam mac_bus_pkg::ipl_t ipl_scc  = 3'b101;
  localparam mac_bus_pkg::ipl_t ipl_none = 3'b111;

endpackage

`default_nettype wire

/* hdl/mac_bus_pkg.sv */
`default_nettype none

package mac_bus_pkg;

  // ==============================
  // Bus widths
  // ==============================
  localparam int addr_w = 23;  // Word address, byte address bits 23:1
  localparam int data_w = 16;

  typedef logic [data_w-1:0] word_t;  // One 16-bit bus word
  typedef logic [7:0]        byte_t;  // Peripheral register byte
  typedef logic [addr_w:1]   waddr_t; // Indexed like the 68000 A23..A1 pins
  typedef logic [2:0]        ipl_t;   // IPL2..IPL0, active low

  // ==============================
  // Address map
  // ==============================

  // Matched against address bits 23:20
  localparam logic [3:0] page_via       = 4'hE;
  localparam logic [3:0] page_scc_mask  = 4'b1101; // Ignore bit 21
  localparam logic [3:0] page_scc_match = 4'b1001; // Pages 1001 and 1011

  // 8-bit peripherals sit on the upper lane
  localparam byte_t fill_byte = 8'hEF; // Low byte of peripheral reads

endpackage

`default_nettype wire
